// File: axil_sram.f
+incdir+source
source/axil_sram_pkg.sv
source/axil_sram_front.sv
source/sram_phy.sv
source/axil_sram.sv
bench/sram_model.sv
bench/axil_sram_checker.sv
bench/axil_sram_tb.sv

// File: bench/axil_sram_checker.sv
`timescale 1ns/10ps

`include "axil_sram_consts.svh"

module axil_sram_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  input  logic                          s_axil_awready,
  input  logic [`AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb,
  input  logic                          s_axil_wvalid,
  input  logic                          s_axil_wready,
  input  axil_sram_pkg::axil_resp_t     s_axil_bresp,
  input  logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic                          s_axil_arvalid,
  input  logic                          s_axil_arready,
  input  logic [`AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
  input  axil_sram_pkg::axil_resp_t     s_axil_rresp,
  input  logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,
  output int                            pass_cnt,
  output int                            fail_cnt
);
  import axil_sram_pkg::*;

  localparam int WORDS = 1 << `SRAM_ADDR_WIDTH;
  localparam int AW    = `AXIL_ADDR_WIDTH;
  localparam int DW    = `AXIL_DATA_WIDTH;

  logic [DW-1:0]   shadow [WORDS];
  logic [AW-1:0]   wr_addr;
  logic [AW-1:0]   rd_addr;
  logic [DW-1:0]   wr_data;
  logic [DW/8-1:0] wr_strb;
  logic [DW-1:0]   rdata_q;
  axil_resp_t      bresp_q;
  axil_resp_t      rresp_q;
  logic            b_held = 1'b0;  // Response seen last cycle without ready
  logic            r_held = 1'b0;
  logic            reset_seen = 1'b0;
  logic            reset_checked = 1'b0;
  logic            ok;

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
    for (int i = 0; i < WORDS; i++) begin
      shadow[i] = DW'(i * 32'h9e37) ^ 16'h5a5a;  // Same power-up fill as the SRAM model
    end
  end

  task automatic compare_value(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] got);
    if (got !== exp) begin
      $display("[FAIL] %s exp 0x%h got 0x%h", name, exp, got);
      fail_cnt++;
      ok = 1'b0;
    end
  endtask

  task automatic protocol_error(input string what);
    $display("Protocol error at %0t ns: %s", $time, what);
    fail_cnt++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      reset_seen <= 1'b1;
    end
  end

  // Sampled mid-cycle, so every value is the one the next rising edge commits
  always @(negedge clk) begin
    if (!rst_n) begin
      b_held = 1'b0;
      r_held = 1'b0;
      if (reset_seen && !reset_checked) begin
        ok = 1'b1;
        compare_value("awready", '0, DW'(s_axil_awready));
        compare_value("wready", '0, DW'(s_axil_wready));
        compare_value("arready", '0, DW'(s_axil_arready));
        compare_value("bvalid", '0, DW'(s_axil_bvalid));
        compare_value("rvalid", '0, DW'(s_axil_rvalid));
        if (ok) begin
          $display("[PASS] reset leaves all ready and valid outputs low");
          pass_cnt++;
        end
        reset_checked = 1'b1;
      end
    end else begin
      if (b_held && (!s_axil_bvalid || s_axil_bresp != bresp_q)) begin
        protocol_error("write response changed while bready was low");
      end
      if (r_held && (!s_axil_rvalid || s_axil_rresp != rresp_q || s_axil_rdata != rdata_q)) begin
        protocol_error("read response changed while rready was low");
      end
      if (s_axil_awready && !s_axil_wvalid) begin
        protocol_error("write address accepted before its data arrived");
      end
      if (s_axil_awready != s_axil_wready) begin
        protocol_error("awready and wready did not rise together");
      end

      if (s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready) begin
        wr_addr = s_axil_awaddr;
        wr_data = s_axil_wdata;
        wr_strb = s_axil_wstrb;
      end
      if (s_axil_arvalid && s_axil_arready) begin
        rd_addr = s_axil_araddr;
      end

      if (s_axil_bvalid && s_axil_bready) begin
        ok = 1'b1;
        compare_value("bresp", DW'(AXIL_OKAY), DW'(s_axil_bresp));
        for (int b = 0; b < DW / 8; b++) begin
          if (wr_strb[b]) begin
            shadow[wr_addr[AW-1:1]][8*b +: 8] = wr_data[8*b +: 8];
          end
        end
        if (ok) begin
          $display("[PASS] write 0x%h data 0x%h strb 0x%h", wr_addr, wr_data, wr_strb);
          pass_cnt++;
        end
      end

      if (s_axil_rvalid && s_axil_rready) begin
        ok = 1'b1;
        compare_value("rresp", DW'(AXIL_OKAY), DW'(s_axil_rresp));
        compare_value("rdata", shadow[rd_addr[AW-1:1]], s_axil_rdata);
        if (ok) begin
          $display("[PASS] read 0x%h data 0x%h", rd_addr, s_axil_rdata);
          pass_cnt++;
        end
      end

      b_held  = s_axil_bvalid && !s_axil_bready;
      r_held  = s_axil_rvalid && !s_axil_rready;
      bresp_q = s_axil_bresp;
      rresp_q = s_axil_rresp;
      rdata_q = s_axil_rdata;
    end
  end

endmodule

// File: bench/axil_sram_tb.sv
`timescale 1ns/10ps

`include "axil_sram_consts.svh"

module axil_sram_tb;
  import axil_sram_pkg::*;

  localparam int AW = `AXIL_ADDR_WIDTH;
  localparam int DW = `AXIL_DATA_WIDTH;

  localparam logic [1:0] K_WR = 2'd0;
  localparam logic [1:0] K_RD = 2'd1;
  localparam logic [1:0] K_RW = 2'd2;  // Read and write issued on the same edge
  localparam logic [3:0] HOLD_RAND = 4'hf;
  localparam int         RAND_HOLD_MAX = 5;

  typedef struct packed {
    logic [1:0]      kind;
    logic [AW-1:0]   waddr;
    logic [DW-1:0]   wdata;
    logic [DW/8-1:0] wstrb;
    logic [AW-1:0]   raddr;
    logic [3:0]      hold;   // Cycles of bready/rready hold-off
    logic            early;  // aw goes out 1 to 3 cycles ahead of w
  } stim_t;

  localparam int N_TESTS = 12;
  localparam stim_t STIM [N_TESTS] = '{
    //  kind  waddr     wdata     strb   raddr     hold       early
    '{K_WR, 16'h0010, 16'h1234, 2'b11, 16'h0000, 4'd0,      1'b0},
    '{K_RD, 16'h0000, 16'h0000, 2'b00, 16'h0010, 4'd0,      1'b0},
    '{K_WR, 16'h0011, 16'habcd, 2'b10, 16'h0000, 4'd0,      1'b0},
    '{K_RD, 16'h0000, 16'h0000, 2'b00, 16'h0010, 4'd0,      1'b0},
    '{K_WR, 16'h0020, 16'h00c3, 2'b01, 16'h0000, 4'd0,      1'b0},
    '{K_RD, 16'h0000, 16'h0000, 2'b00, 16'h0020, 4'd4,      1'b0},
    '{K_WR, 16'h0030, 16'hbeef, 2'b11, 16'h0000, 4'd5,      1'b0},
    '{K_RW, 16'h0040, 16'hc0de, 2'b11, 16'h0100, 4'd0,      1'b0},
    '{K_WR, 16'h0050, 16'h7e81, 2'b11, 16'h0000, HOLD_RAND, 1'b1},
    '{K_RD, 16'h0000, 16'h0000, 2'b00, 16'h0050, HOLD_RAND, 1'b0},
    '{K_RW, 16'h0060, 16'h3c3c, 2'b01, 16'h0030, HOLD_RAND, 1'b0},
    '{K_RD, 16'h0000, 16'h0000, 2'b00, 16'h0061, 4'd0,      1'b0}
  };

  logic clk = 1'b0;
  logic rst_n;
  int   seed = 32'h73a1;
  int   cycles = 0;
  int   limit;
  int   pass_cnt;
  int   fail_cnt;

  logic [AW-1:0]   s_axil_awaddr;
  logic            s_axil_awvalid;
  logic            s_axil_awready;
  logic [DW-1:0]   s_axil_wdata;
  logic [DW/8-1:0] s_axil_wstrb;
  logic            s_axil_wvalid;
  logic            s_axil_wready;
  axil_resp_t      s_axil_bresp;
  logic            s_axil_bvalid;
  logic            s_axil_bready;
  logic [AW-1:0]   s_axil_araddr;
  logic            s_axil_arvalid;
  logic            s_axil_arready;
  logic [DW-1:0]   s_axil_rdata;
  axil_resp_t      s_axil_rresp;
  logic            s_axil_rvalid;
  logic            s_axil_rready;

  logic [`SRAM_ADDR_WIDTH-1:0] sram_addr;
  wire  [DW-1:0]               sram_data;
  logic [DW/8-1:0]             sram_be_n;
  logic                        sram_we_n;
  logic                        sram_oe_n;
  logic                        sram_ce_n;

  always #50 clk = ~clk;

  axil_sram UUT (.*);

  sram_model mem_i (
    .addr (sram_addr),
    .data (sram_data),
    .be_n (sram_be_n),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .ce_n (sram_ce_n)
  );

  axil_sram_checker chk (.*);

  function automatic int largest_hold();
    int m;
    m = 0;
    for (int i = 0; i < N_TESTS; i++) begin
      if (STIM[i].hold == HOLD_RAND) begin
        m = (m > RAND_HOLD_MAX) ? m : RAND_HOLD_MAX;
      end else if (int'(STIM[i].hold) > m) begin
        m = int'(STIM[i].hold);
      end
    end
    return m;
  endfunction

  function automatic int expected_passes();
    int n;
    n = 1;  // Reset state
    for (int i = 0; i < N_TESTS; i++) begin
      n += (STIM[i].kind == K_RW) ? 2 : 1;
    end
    return n;
  endfunction

  task automatic issue_write(input logic [AW-1:0] a, input logic [DW-1:0] d,
                             input logic [DW/8-1:0] s, input logic early);
    int lag;
    lag = early ? 1 + int'($unsigned($random(seed)) % 3) : 0;
    @(posedge clk);
    s_axil_awaddr  <= a;
    s_axil_awvalid <= 1'b1;
    repeat (lag) @(posedge clk);
    s_axil_wdata  <= d;
    s_axil_wstrb  <= s;
    s_axil_wvalid <= 1'b1;
    do begin
      @(negedge clk);
    end while (!s_axil_awready);
    @(posedge clk);
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
  endtask

  task automatic issue_read(input logic [AW-1:0] a);
    @(posedge clk);
    s_axil_araddr  <= a;
    s_axil_arvalid <= 1'b1;
    do begin
      @(negedge clk);
    end while (!s_axil_arready);
    @(posedge clk);
    s_axil_arvalid <= 1'b0;
  endtask

  task automatic accept_write_response(input int hold);
    do begin
      @(negedge clk);
    end while (!s_axil_bvalid);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    s_axil_bready <= 1'b1;
    @(posedge clk);
    s_axil_bready <= 1'b0;
  endtask

  task automatic accept_read_response(input int hold);
    do begin
      @(negedge clk);
    end while (!s_axil_rvalid);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    s_axil_rready <= 1'b1;
    @(posedge clk);
    s_axil_rready <= 1'b0;
  endtask

  task automatic apply_entry(input stim_t e);
    int hold;
    if (e.hold == HOLD_RAND) begin
      hold = int'($unsigned($random(seed)) % (RAND_HOLD_MAX + 1));
    end else begin
      hold = int'(e.hold);
    end
    case (e.kind)
      K_WR: begin
        issue_write(e.waddr, e.wdata, e.wstrb, e.early);
        accept_write_response(hold);
      end
      K_RD: begin
        issue_read(e.raddr);
        accept_read_response(hold);
      end
      default: begin
        fork
          issue_write(e.waddr, e.wdata, e.wstrb, e.early);
          issue_read(e.raddr);
        join
        fork
          accept_write_response(hold);
          accept_read_response(hold);
        join
      end
    endcase
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Run timed out after %0d cycles without completing the stimulus table", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rst_n          <= 1'b0;
    s_axil_awaddr  <= '0;
    s_axil_awvalid <= 1'b0;
    s_axil_wdata   <= '0;
    s_axil_wstrb   <= '0;
    s_axil_wvalid  <= 1'b0;
    s_axil_bready  <= 1'b0;
    s_axil_araddr  <= '0;
    s_axil_arvalid <= 1'b0;
    s_axil_rready  <= 1'b0;
    limit = N_TESTS * (12 + largest_hold()) + 20;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      apply_entry(STIM[i]);
    end
    repeat (2) @(posedge clk);
    $display("Tests passed %0d of %0d, checks failed %0d",
             pass_cnt, expected_passes(), fail_cnt);
    if (fail_cnt == 0 && pass_cnt == expected_passes()) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: bench/sram_model.sv
`timescale 1ns/10ps

`include "axil_sram_consts.svh"

module sram_model (
  input  logic [`SRAM_ADDR_WIDTH-1:0]   addr,
  inout  wire  [`AXIL_DATA_WIDTH-1:0]   data,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] be_n,
  input  logic                          we_n,
  input  logic                          oe_n,
  input  logic                          ce_n
);
  localparam int WORDS = 1 << `SRAM_ADDR_WIDTH;
  localparam int DW    = `AXIL_DATA_WIDTH;

  logic [DW-1:0] mem [WORDS];

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = DW'(i * 32'h9e37) ^ 16'h5a5a;  // Power-up contents differ on every address bit
    end
  end

  // Outputs only while selected, enabled and not being written
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

  // Write lands on the rising edge of we_n
  always @(posedge we_n) begin
    if (ce_n === 1'b0) begin
      for (int b = 0; b < DW / 8; b++) begin
        if (!be_n[b]) begin
          mem[addr][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the axil_sram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps \
  -f axil_sram.f --top-module axil_sram_tb -o axil_sram_sim

out=$(./obj_dir/axil_sram_sim)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// File: source/axil_sram.sv
`timescale 1ns/10ps

`include "axil_sram_consts.svh"

module axil_sram (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [`AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output axil_sram_pkg::axil_resp_t     s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,

  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [`AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
  output axil_sram_pkg::axil_resp_t     s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,

  output logic [`SRAM_ADDR_WIDTH-1:0]   sram_addr,
  inout  wire  [`AXIL_DATA_WIDTH-1:0]   sram_data,
  output logic [`AXIL_DATA_WIDTH/8-1:0] sram_be_n,
  output logic                          sram_we_n,
  output logic                          sram_oe_n,
  output logic                          sram_ce_n
);
  import axil_sram_pkg::*;

  // Front end to sequencer
  logic                          req;
  sram_op_t                      op;
  logic [`SRAM_ADDR_WIDTH-1:0]   addr;
  logic [`AXIL_DATA_WIDTH-1:0]   wdata;
  logic [`AXIL_DATA_WIDTH/8-1:0] be;
  logic [`AXIL_DATA_WIDTH-1:0]   rdata;
  logic                          done;

  axil_sram_front front_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .req            (req),
    .op             (op),
    .addr           (addr),
    .wdata_o        (wdata),
    .be             (be),
    .rdata_i        (rdata),
    .done           (done)
  );

  sram_phy phy_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .op        (op),
    .addr      (addr),
    .wdata     (wdata),
    .be        (be),
    .rdata     (rdata),
    .done      (done),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_be_n (sram_be_n),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

endmodule

// File: source/axil_sram_consts.svh
`ifndef AXIL_SRAM_CONSTS_SVH
`define AXIL_SRAM_CONSTS_SVH

// AXI side
`define AXIL_ADDR_WIDTH 16
`define AXIL_DATA_WIDTH 16

// SRAM side, word addressed
`define SRAM_ADDR_WIDTH 15

`define SRAM_WRITE_CYCLES 2  // we_n low time in clocks
`define SRAM_READ_CYCLES 2   // oe_n low time before sampling

`endif

// File: source/axil_sram_front.sv
`timescale 1ns/10ps

`include "axil_sram_consts.svh"

module axil_sram_front (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic [`AXIL_ADDR_WIDTH-1:0]       s_axil_awaddr,
  input  logic                              s_axil_awvalid,
  output logic                              s_axil_awready,
  input  logic [`AXIL_DATA_WIDTH-1:0]       s_axil_wdata,
  input  logic [`AXIL_DATA_WIDTH/8-1:0]     s_axil_wstrb,
  input  logic                              s_axil_wvalid,
  output logic                              s_axil_wready,
  output axil_sram_pkg::axil_resp_t         s_axil_bresp,
  output logic                              s_axil_bvalid,
  input  logic                              s_axil_bready,

  input  logic [`AXIL_ADDR_WIDTH-1:0]       s_axil_araddr,
  input  logic                              s_axil_arvalid,
  output logic                              s_axil_arready,
  output logic [`AXIL_DATA_WIDTH-1:0]       s_axil_rdata,
  output axil_sram_pkg::axil_resp_t         s_axil_rresp,
  output logic                              s_axil_rvalid,
  input  logic                              s_axil_rready,

  output logic                              req,
  output axil_sram_pkg::sram_op_t           op,
  output logic [`SRAM_ADDR_WIDTH-1:0]       addr,
  output logic [`AXIL_DATA_WIDTH-1:0]       wdata_o,
  output logic [`AXIL_DATA_WIDTH/8-1:0]     be,
  input  logic [`AXIL_DATA_WIDTH-1:0]       rdata_i,
  input  logic                              done
);
  import axil_sram_pkg::*;

  localparam int STRB_W = `AXIL_DATA_WIDTH / 8;

  logic busy;     // Access sitting in the sequencer
  logic last_wr;  // Last grant went to the write side
  logic idle;
  logic wr_pend;
  logic rd_pend;
  logic grant_wr;
  logic grant_rd;

  // A held response blocks only its own channel
  assign idle    = !busy && !req;
  assign wr_pend = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
  assign rd_pend = s_axil_arvalid && !s_axil_rvalid;

  // Take turns when both sides are waiting
  assign grant_wr = idle && wr_pend && (!rd_pend || !last_wr);
  assign grant_rd = idle && rd_pend && !grant_wr;

  assign s_axil_awready = grant_wr;  // aw only goes with its w
  assign s_axil_wready  = grant_wr;
  assign s_axil_arready = grant_rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req           <= 1'b0;
      busy          <= 1'b0;
      last_wr       <= 1'b0;
      s_axil_bvalid <= 1'b0;
      s_axil_rvalid <= 1'b0;
    end else begin
      req <= grant_wr || grant_rd;

      if (req) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end

      if (grant_wr) begin
        last_wr <= 1'b1;
      end else if (grant_rd) begin
        last_wr <= 1'b0;
      end

      if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (done && op == SRAM_WRITE) begin
        s_axil_bvalid <= 1'b1;
      end

      if (s_axil_rvalid && s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
      if (done && op == SRAM_READ) begin
        s_axil_rvalid <= 1'b1;
      end
    end
  end

  // Request fields stay put for the whole access
  always_ff @(posedge clk) begin
    if (grant_wr) begin
      op      <= SRAM_WRITE;
      addr    <= s_axil_awaddr[`AXIL_ADDR_WIDTH-1:1];  // Byte LSB only picks lanes
      wdata_o <= s_axil_wdata;
      be      <= s_axil_wstrb;
    end else if (grant_rd) begin
      op   <= SRAM_READ;
      addr <= s_axil_araddr[`AXIL_ADDR_WIDTH-1:1];
      be   <= {STRB_W{1'b1}};
    end

    if (done && op == SRAM_WRITE) begin
      s_axil_bresp <= AXIL_OKAY;
    end
    if (done && op == SRAM_READ) begin
      s_axil_rresp <= AXIL_OKAY;
      s_axil_rdata <= rdata_i;
    end
  end

  a_b_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp)
  );

  a_r_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    s_axil_rvalid && !s_axil_rready |=>
      s_axil_rvalid && $stable(s_axil_rresp) && $stable(s_axil_rdata)
  );

  // Sequencer only answers the access in flight
  a_one_access : assert property (
    @(posedge clk) disable iff (!rst_n)
    done |-> busy
  );

endmodule

// File: source/axil_sram_pkg.sv
package axil_sram_pkg;

  // Kind of access handed from the AXI front end to the pin sequencer
  typedef enum logic {
    SRAM_READ  = 1'b0,
    SRAM_WRITE = 1'b1
  } sram_op_t;

  // AXI response codes
  // The bridge only ever answers OKAY, since every address maps to a word
  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_t;

endpackage

// File: source/sram_phy.sv
`timescale 1ns/10ps

`include "axil_sram_consts.svh"

module sram_phy (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          req,
  input  axil_sram_pkg::sram_op_t       op,
  input  logic [`SRAM_ADDR_WIDTH-1:0]   addr,
  input  logic [`AXIL_DATA_WIDTH-1:0]   wdata,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] be,
  output logic [`AXIL_DATA_WIDTH-1:0]   rdata,
  output logic                          done,

  output logic [`SRAM_ADDR_WIDTH-1:0]   sram_addr,
  inout  wire  [`AXIL_DATA_WIDTH-1:0]   sram_data,
  output logic [`AXIL_DATA_WIDTH/8-1:0] sram_be_n,
  output logic                          sram_we_n,
  output logic                          sram_oe_n,
  output logic                          sram_ce_n
);
  import axil_sram_pkg::*;

  localparam int STRB_W     = `AXIL_DATA_WIDTH / 8;
  localparam int MAX_CYCLES = (`SRAM_WRITE_CYCLES > `SRAM_READ_CYCLES) ?
                              `SRAM_WRITE_CYCLES : `SRAM_READ_CYCLES;
  localparam int CNT_W      = (MAX_CYCLES > 1) ? $clog2(MAX_CYCLES) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,   // Pins settle before the strobe
    ST_STROBE,  // we_n or oe_n low
    ST_HOLD     // Write address and data held past we_n
  } state_t;

  state_t                      state;
  logic [CNT_W-1:0]            cnt;
  sram_op_t                    op_q;
  logic                        drive_en;
  logic [`AXIL_DATA_WIDTH-1:0] data_out;

  assign sram_data = drive_en ? data_out : 'z;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      cnt       <= '0;
      done      <= 1'b0;
      drive_en  <= 1'b0;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b1;
      sram_be_n <= {STRB_W{1'b1}};
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req) begin
            sram_ce_n <= 1'b0;
            sram_be_n <= ~be;
            drive_en  <= (op == SRAM_WRITE);  // Reads leave the bus released
            state     <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          if (op_q == SRAM_WRITE) begin
            sram_we_n <= 1'b0;
            cnt       <= CNT_W'(`SRAM_WRITE_CYCLES - 1);
          end else begin
            sram_oe_n <= 1'b0;
            cnt       <= CNT_W'(`SRAM_READ_CYCLES - 1);
          end
          state <= ST_STROBE;
        end
        ST_STROBE: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else if (op_q == SRAM_WRITE) begin
            sram_we_n <= 1'b1;
            state     <= ST_HOLD;
          end else begin
            sram_oe_n <= 1'b1;  // Data sampled on this edge
            sram_ce_n <= 1'b1;
            sram_be_n <= {STRB_W{1'b1}};
            done      <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        ST_HOLD: begin
          drive_en  <= 1'b0;
          sram_ce_n <= 1'b1;
          sram_be_n <= {STRB_W{1'b1}};
          done      <= 1'b1;
          state     <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      op_q      <= op;
      sram_addr <= addr;
      data_out  <= wdata;
    end
    if (state == ST_STROBE && cnt == '0 && op_q == SRAM_READ) begin
      rdata <= sram_data;
    end
  end

  a_no_overlap : assert property (
    @(posedge clk) disable iff (!rst_n)
    sram_we_n || sram_oe_n
  );

  // No contention with the SRAM output drivers
  a_bus_turn : assert property (
    @(posedge clk) disable iff (!rst_n)
    drive_en |-> sram_oe_n
  );

endmodule
